/* sources.f */
+incdir+source
source/tx_mux_pkg.sv
source/port_queue.sv
source/rr_scheduler.sv
source/egress_stage.sv
source/tx_mux_top.sv
verification/tx_mux_checker.sv
verification/tb_tx_mux.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_tx_mux -f sources.f

# Let the run continue past checker errors so the testbench can count them
./obj_dir/Vtb_tx_mux +verilator+error+limit+1000 | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* verification/tb_tx_mux.sv */
`include "tx_mux_config.svh"

module tb_tx_mux;

    import tx_mux_pkg::*;

    localparam int N_PORTS = `TX_N_PORTS;
    localparam int DEPTH   = `TX_QUEUE_DEPTH;
    localparam int N_TESTS = 5;

    logic               clk = 1'b0;
    logic               reset_q = 1'b1;
    tx_req_t            port_req [N_PORTS] = '{default: '0};
    logic [N_PORTS-1:0] port_credit;
    tx_req_t            host_req;
    logic               host_credit = 1'b0;

    int         seed = 78655;
    string      cur_test;
    int         errors;
    int         checks;
    int         test_errors;
    int         cyc;
    int         xfers;                          // Host transfers seen so far
    int         host_delay;
    logic       host_hold = 1'b0;               // Host keeps its credits
    int         sent [N_PORTS];
    int         returned [N_PORTS];
    tx_req_t    pend [N_PORTS][$];              // Waiting at each sender
    tx_req_t    exp_q [N_PORTS][$];             // As the host should see them
    int         ret_due [$];                    // Cycle each host credit goes back
    int         out_ports [$];

    tx_mux_top dut
    (
        .clk         (clk),
        .reset_q     (reset_q),
        .port_req    (port_req),
        .port_credit (port_credit),
        .host_req    (host_req),
        .host_credit (host_credit)
    );

    always #5 clk = ~clk;

    initial
    begin
        #(N_TESTS * 2000);
        $display("Timeout: tests did not finish within %0d time units", N_TESTS * 2000);
        $display("TB FAILED");
        $finish;
    end

    task automatic check_eq(string what, int want, int got);
        checks++;
        assert (want == got)
        else
        begin
            $display("error %s %s: expected %0d, actual %0d", cur_test, what, want, got);
            errors++;
        end
    endtask

    function automatic tx_req_t random_req();
        tx_req_t     r;
        logic [95:0] bits;
        bits = {$random(seed), $random(seed), $random(seed)};
        r.valid = 1'b1;
        r.kind = tx_kind_e'(bits[95]);
        r.body = bits[71:0];
        return r;
    endfunction

    // Read tag at 39:32, write tag in the low byte
    function automatic tx_req_t tag_with_port(tx_req_t r, int p);
        logic [71:0] b;
        b = r.body;
        if (r.kind == TX_RD)
            b[39:32] = 8'(p);
        else
            b[7:0] = 8'(p);
        r.body = b;
        return r;
    endfunction

    task automatic push_req(int p, tx_req_t r);
        pend[p].push_back(r);
        exp_q[p].push_back(tag_with_port(r, p));
    endtask

    task automatic enqueue(int p, int n);
        for (int i = 0; i < n; i++)
            push_req(p, random_req());
    endtask

    task automatic check_host_req();
        logic [71:0] b;
        tx_req_t     want;
        int          pid;
        b = host_req.body;
        pid = (host_req.kind == TX_RD) ? int'(b[39:32]) : int'(b[7:0]);
        xfers++;
        ret_due.push_back(cyc + host_delay);
        checks++;
        assert (pid < N_PORTS && exp_q[pid].size() > 0)
        begin
            want = exp_q[pid].pop_front();
            out_ports.push_back(pid);
            checks++;
            assert (host_req == want)
            else
            begin
                $display("error %s port %0d: expected %h, actual %h", cur_test, pid, want,
                         host_req);
                errors++;
            end
        end
        else
        begin
            $display("Host sent a request with port tag %0d that no port is waiting on", pid);
            errors++;
        end
    endtask

    // Sender and host models, all sampling and driving on the falling edge
    always @(negedge clk)
    begin
        if (!reset_q)
        begin
            cyc++;
            for (int p = 0; p < N_PORTS; p++)
                if (port_credit[p])
                    returned[p]++;
            if (host_req.valid)
                check_host_req();
            if (!host_hold && ret_due.size() > 0 && ret_due[0] <= cyc)
            begin
                host_credit = 1'b1;
                void'(ret_due.pop_front());
            end
            else
                host_credit = 1'b0;
            for (int p = 0; p < N_PORTS; p++)
            begin
                if (pend[p].size() > 0 && sent[p] - returned[p] < DEPTH)
                begin
                    port_req[p] = pend[p].pop_front();
                    sent[p]++;
                end
                else
                    port_req[p] = '0;
            end
        end
    end

    function automatic bit idle();
        for (int p = 0; p < N_PORTS; p++)
            if (pend[p].size() > 0 || exp_q[p].size() > 0)
                return 1'b0;
        return ret_due.size() == 0;
    endfunction

    task automatic wait_drained();
        while (!idle())
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // With the host holding credits, wait for every sender to stall
    task automatic check_stall();
        bit blocked;
        int base;
        base = xfers;
        do
        begin
            @(negedge clk);
            blocked = 1'b1;
            for (int p = 0; p < N_PORTS; p++)
                if (pend[p].size() > 0 && sent[p] - returned[p] < DEPTH)
                    blocked = 1'b0;
        end
        while (!blocked);
        repeat (12) @(negedge clk);
        check_eq("transfers without host credit", `TX_HOST_CREDITS, xfers - base);
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        $display("%s: %s", cur_test, (errors == test_errors) ? "ok" : "failed");
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        repeat (8)
        begin
            @(negedge clk);
            check_eq("host valid in reset", 0, int'(host_req.valid));
            check_eq("port credit in reset", 0, int'(port_credit));
        end
        reset_q = 1'b0;
        @(negedge clk);
        check_eq("host valid after reset", 0, int'(host_req.valid));
        check_eq("port credit after reset", 0, int'(port_credit));
        host_hold = 1'b1;
        enqueue(0, DEPTH);
        check_stall();
        host_hold = 1'b0;
        wait_drained();
        finish_test();
    endtask

    task automatic test_single_port_order();
        tx_req_t r;
        start_test("single_port_order");
        host_delay = 1;
        for (int i = 0; i < 12; i++)
        begin
            r = random_req();
            r.kind = (i % 3 == 0) ? TX_WR : TX_RD;
            push_req(2, r);
        end
        wait_drained();
        finish_test();
    endtask

    task automatic test_round_robin();
        int base;
        start_test("round_robin");
        host_delay = 0;
        base = out_ports.size();
        host_hold = 1'b1;
        for (int p = 0; p < N_PORTS; p++)
            enqueue(p, 2 * DEPTH);
        check_stall();
        host_hold = 1'b0;
        wait_drained();
        for (int i = base; i < base + N_PORTS * DEPTH - 1; i++)
            check_eq("next port", (out_ports[i] + 1) % N_PORTS, out_ports[i + 1]);
        finish_test();
    endtask

    task automatic test_host_backpressure();
        start_test("host_backpressure");
        host_delay = 2;
        host_hold = 1'b1;
        for (int p = 0; p < N_PORTS; p++)
            enqueue(p, 6);
        check_stall();
        host_hold = 1'b0;
        wait_drained();
        finish_test();
    endtask

    task automatic test_port_credit_return();
        start_test("port_credit_return");
        host_delay = 3;
        for (int p = 0; p < N_PORTS; p++)
            enqueue(p, 3 * DEPTH);
        wait_drained();
        for (int p = 0; p < N_PORTS; p++)
            check_eq("credits returned", sent[p], returned[p]);
        finish_test();
    endtask

    initial
    begin
        test_reset_state();
        test_single_port_order();
        test_round_robin();
        test_host_backpressure();
        test_port_credit_return();
        checks++;
        assert (dut.u_chk.fail_count == 0)
        else
        begin
            $display("Bound checker assertions failed %0d times", dut.u_chk.fail_count);
            errors++;
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* verification/tx_mux_checker.sv */
`include "tx_mux_config.svh"

module tx_mux_checker
(
    input logic                     clk,
    input logic                     reset_q,
    input tx_mux_pkg::tx_req_t      host_req,
    input logic [`TX_N_PORTS-1:0]   deq_grant,
    input tx_mux_pkg::credit_cnt_t  credit_cnt
);

    int fail_count = 0;

    // A transfer comes from a grant made one cycle earlier with credit in hand
    a_host_credit: assert property (@(posedge clk) disable iff (reset_q)
        host_req.valid |-> $past(credit_cnt) != '0)
    else
    begin
        fail_count++;
        $error("host request sent without host credit");
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset_q)
        $onehot0(deq_grant))
    else
    begin
        fail_count++;
        $error("more than one queue granted in a cycle");
    end

    a_idle_after_reset: assert property (@(posedge clk) $fell(reset_q) |=> !host_req.valid)
    else
    begin
        fail_count++;
        $error("host request valid in the cycle after reset");
    end

endmodule

bind tx_mux_top tx_mux_checker u_chk
(
    .clk        (clk),
    .reset_q    (reset_q),
    .host_req   (host_req),
    .deq_grant  (deq_grant),
    .credit_cnt (u_sched.credit_cnt)
);

/* source/tx_mux_top.sv */
`include "tx_mux_config.svh"

module tx_mux_top
(
    input  logic                    clk,
    input  logic                    reset_q,
    input  tx_mux_pkg::tx_req_t     port_req [`TX_N_PORTS],
    output logic [`TX_N_PORTS-1:0]  port_credit,
    output tx_mux_pkg::tx_req_t     host_req,
    input  logic                    host_credit
);

    import tx_mux_pkg::*;

    tx_req_t                    head_req [`TX_N_PORTS];
    tx_req_t                    sel_req;
    logic [`TX_N_PORTS-1:0]     not_empty;
    logic [`TX_N_PORTS-1:0]     deq_grant;
    port_id_t                   grant_port;
    logic                       grant_valid;

    genvar i;
    generate
        for (i = 0; i < `TX_N_PORTS; i++)
        begin : gen_queue
            port_queue u_queue
            (
                .clk        (clk),
                .reset_q    (reset_q),
                .req        (port_req[i]),
                .deq        (deq_grant[i]),
                .head_req   (head_req[i]),
                .not_empty  (not_empty[i]),
                .credit     (port_credit[i])
            );
        end
    endgenerate

    rr_scheduler u_sched
    (
        .clk            (clk),
        .reset_q        (reset_q),
        .not_empty      (not_empty),
        .host_credit    (host_credit),
        .deq_grant      (deq_grant),
        .grant_port     (grant_port),
        .grant_valid    (grant_valid)
    );

    assign sel_req = head_req[grant_port];      // Head of the granted queue

    egress_stage u_egress
    (
        .clk            (clk),
        .reset_q        (reset_q),
        .grant_valid    (grant_valid),
        .grant_port     (grant_port),
        .req            (sel_req),
        .host_req       (host_req)
    );

endmodule

/* source/egress_stage.sv */
`include "tx_mux_config.svh"

module egress_stage
(
    input  logic                    clk,
    input  logic                    reset_q,
    input  logic                    grant_valid,
    input  tx_mux_pkg::port_id_t    grant_port,
    input  tx_mux_pkg::tx_req_t     req,
    output tx_mux_pkg::tx_req_t     host_req
);

    import tx_mux_pkg::*;

    tx_req_t stamped;

    // The tag field sits in a different spot per view
    always_comb
    begin
        stamped       = req;
        stamped.valid = grant_valid;
        if (req.kind == TX_RD)
            stamped.body.rd.mdata = `TX_MDATA_W'(grant_port);
        else
            stamped.body.wr.mdata = `TX_MDATA_W'(grant_port);
    end

    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            host_req.valid <= 1'b0;
        end
        else if (grant_valid)
        begin
            host_req <= stamped;
        end
        else
        begin
            host_req.valid <= 1'b0;             // Payload held, only valid drops
        end
    end

endmodule

/* source/rr_scheduler.sv */
`include "tx_mux_config.svh"

module rr_scheduler
(
    input  logic                        clk,
    input  logic                        reset_q,
    input  logic [`TX_N_PORTS-1:0]      not_empty,
    input  logic                        host_credit,
    output logic [`TX_N_PORTS-1:0]      deq_grant,
    output tx_mux_pkg::port_id_t        grant_port,
    output logic                        grant_valid
);

    import tx_mux_pkg::*;

    port_id_t       ptr;                        // Highest priority port this cycle
    credit_cnt_t    credit_cnt;
    logic           found;

    // First non-empty port at or after ptr, wrapping
    always_comb
    begin
        int idx;
        found      = 1'b0;
        grant_port = '0;
        for (int i = 0; i < `TX_N_PORTS; i++)
        begin
            idx = (int'(ptr) + i) % `TX_N_PORTS;
            if (!found && not_empty[idx])
            begin
                found      = 1'b1;
                grant_port = port_id_t'(idx);
            end
        end
    end

    assign grant_valid = found && (credit_cnt != '0);

    always_comb
    begin
        for (int p = 0; p < `TX_N_PORTS; p++)
            deq_grant[p] = grant_valid && (grant_port == port_id_t'(p));
    end

    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            ptr        <= '0;
            credit_cnt <= credit_cnt_t'(`TX_HOST_CREDITS);
        end
        else
        begin
            if (grant_valid)
            begin
                if (grant_port == port_id_t'(`TX_N_PORTS - 1))
                    ptr <= '0;
                else
                    ptr <= grant_port + 1'b1;
            end
            case ({grant_valid, host_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;  // Send and return cancel out
            endcase
        end
    end

endmodule

/* source/port_queue.sv */
`include "tx_mux_config.svh"

module port_queue
(
    input  logic                clk,
    input  logic                reset_q,
    input  tx_mux_pkg::tx_req_t req,
    input  logic                deq,
    output tx_mux_pkg::tx_req_t head_req,
    output logic                not_empty,
    output logic                credit
);

    import tx_mux_pkg::*;

    localparam int PTR_W = $clog2(`TX_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`TX_QUEUE_DEPTH + 1);

    tx_req_t            in_q;                   // Input stage
    tx_req_t            mem [`TX_QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`TX_QUEUE_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign push      = in_q.valid;
    assign pop       = deq && not_empty;       // Scheduler only grants non-empty queues
    assign not_empty = (count != '0);
    assign head_req  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset_q)
            in_q.valid <= 1'b0;
        else
            in_q <= req;
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_q;
    end

    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= pop;                      // One credit back per drained entry
        end
    end

endmodule

/* source/tx_mux_pkg.sv */
`include "tx_mux_config.svh"

package tx_mux_pkg;

    // Read view puts mdata at 39:32, above the address
    typedef struct packed {
        logic [27:0]               rsvd;
        logic [3:0]                len;     // Cache lines
        logic [`TX_MDATA_W-1:0]    mdata;
        logic [`TX_ADDR_W-1:0]     addr;
    } tx_rd_view_t;

    // Write view carries data, mdata in the low byte
    typedef struct packed {
        logic [`TX_ADDR_W-1:0]     addr;
        logic [`TX_DATA_W-1:0]     data;
        logic [`TX_MDATA_W-1:0]    mdata;
    } tx_wr_view_t;

    typedef union packed {
        tx_rd_view_t rd;
        tx_wr_view_t wr;
    } tx_body_u;

    typedef enum logic {
        TX_RD = 1'b0,
        TX_WR = 1'b1
    } tx_kind_e;

    typedef struct packed {
        logic       valid;
        tx_kind_e   kind;
        tx_body_u   body;
    } tx_req_t;

    typedef logic [$clog2(`TX_N_PORTS)-1:0] port_id_t;

    typedef logic [$clog2(`TX_HOST_CREDITS+1)-1:0] credit_cnt_t;

endpackage

/* source/tx_mux_config.svh */
`ifndef TX_MUX_CONFIG_SVH
`define TX_MUX_CONFIG_SVH

`define TX_N_PORTS      4
`define TX_QUEUE_DEPTH  8       // Also the credits each sender starts with
`define TX_HOST_CREDITS 4

`define TX_ADDR_W       32
`define TX_DATA_W       32
`define TX_MDATA_W      8

`endif
